/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;
    localparam int pmem_depth = 256;
    localparam int ram_depth = 256;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [$clog2(pmem_depth)-1:0] pmem_addr_t;
    typedef logic [$clog2(ram_depth)-1:0] ram_addr_t;
    typedef logic [7:0] byte_t;

    // Custom-0 carries putc and custom-1 carries halt
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_putc   = 7'b0001011,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_halt   = 7'b0101011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic [1:0] {src1_rs1, src1_zero, src1_pc} rd_src1_e;
    typedef enum logic [1:0] {src2_rs2, src2_imm, src2_four, src2_upper_imm} rd_src2_e;
    typedef enum logic {pc_base_pc, pc_base_rs1} pc_src1_e;
    typedef enum logic [1:0] {next_seq, next_if_zero, next_if_nonzero, next_always} next_pc_e;
    typedef enum logic {wb_alu, wb_ram} wb_src_e;

    typedef enum logic [2:0] {
        st_load,
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } seq_state_e;

    typedef struct packed {
        word_t data;
        logic  last;
    } load_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_out_t;

    typedef struct packed {
        alu_op_e  alu_op;
        rd_src1_e rd_src1;
        rd_src2_e rd_src2;
        pc_src1_e pc_src1;
        next_pc_e next_pc;
        wb_src_e  wb_src;
        logic     reg_write;
        logic     ram_write;
        logic     putc;
        logic     halt;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1;
        word_t     rs2;
        word_t     imm;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1;
        word_t     rs2;
        reg_addr_t rd;
        word_t     alu_result;
        logic      zero;
        word_t     target;
        ctrl_t     ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } wb_write_t;

endpackage

`default_nettype wire

/* rtl/stage_sequencer.sv */
`default_nettype none

module stage_sequencer (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  load_valid,
    input  wire  load_last,
    input  wire  putc_pending,
    input  wire  halt_seen,
    input  wire  out_ready,
    output logic load_ready,
    output logic fetch_en,
    output logic decode_en,
    output logic execute_en,
    output logic memory_en,
    output logic writeback_en
);

    cpu_pkg::seq_state_e state;
    cpu_pkg::seq_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::st_load: begin
                if (load_valid && load_last) begin
                    state_next = cpu_pkg::st_fetch;
                end
            end
            cpu_pkg::st_fetch:   state_next = cpu_pkg::st_decode;
            cpu_pkg::st_decode:  state_next = cpu_pkg::st_execute;
            cpu_pkg::st_execute: state_next = cpu_pkg::st_memory;
            cpu_pkg::st_memory: begin
                // Halt skips writeback; a blocked putc holds here
                if (halt_seen) begin
                    state_next = cpu_pkg::st_load;
                end else if (!putc_pending || out_ready) begin
                    state_next = cpu_pkg::st_writeback;
                end
            end
            default: state_next = cpu_pkg::st_fetch;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cpu_pkg::st_load;
        end else begin
            state <= state_next;
        end
    end

    assign load_ready   = (state == cpu_pkg::st_load);
    assign fetch_en     = (state == cpu_pkg::st_fetch);
    assign decode_en    = (state == cpu_pkg::st_decode);
    assign execute_en   = (state == cpu_pkg::st_execute);
    assign memory_en    = (state == cpu_pkg::st_memory);
    assign writeback_en = (state == cpu_pkg::st_writeback);

    // A putc never shares its memory step with a halt
    assert property (@(posedge clk) disable iff (!arst_n)
        memory_en && putc_pending |-> !halt_seen);

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     load_valid,
    input  wire                     load_ready,
    input  wire cpu_pkg::load_t     load,
    input  wire                     fetch_en,
    input  wire                     writeback_en,
    input  wire cpu_pkg::word_t     next_pc,
    output cpu_pkg::fetch_out_t     fetch_out
);

    cpu_pkg::word_t      pc;
    cpu_pkg::pmem_addr_t load_addr;
    cpu_pkg::word_t      pmem [cpu_pkg::pmem_depth];
    cpu_pkg::word_t      instr;
    logic                load_fire;

    assign load_fire = load_valid && load_ready;

    // A new program always starts at address zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (load_fire) begin
            pc <= '0;
        end else if (writeback_en) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_addr <= '0;
        end else if (load_fire) begin
            load_addr <= load.last ? '0 : load_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_fire) begin
            pmem[load_addr] <= load.data;
        end
    end

    assign instr = pmem[cpu_pkg::pmem_addr_t'(pc >> 2)];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_out <= '0;
        end else if (fetch_en) begin
            fetch_out.pc    <= pc;
            fetch_out.instr <= instr;
        end
    end

    // Targets from the memory stage keep the PC word aligned
    assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      decode_en,
    input  wire cpu_pkg::fetch_out_t fetch_out,
    input  wire cpu_pkg::wb_write_t  wb_write,
    output cpu_pkg::id_ex_t          id_ex
);

    cpu_pkg::word_t     instr;
    cpu_pkg::opcode_e   opcode;
    logic [2:0]         funct3;
    cpu_pkg::reg_addr_t rs1_addr;
    cpu_pkg::reg_addr_t rs2_addr;
    cpu_pkg::word_t     imm;
    cpu_pkg::ctrl_t     ctrl;
    cpu_pkg::word_t     regs [32];
    cpu_pkg::word_t     rs1_data;
    cpu_pkg::word_t     rs2_data;

    function automatic cpu_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
                                                        input logic alt_op);
        cpu_pkg::alu_op_e op;
        case (f3)
            3'b000: begin
                if (alt_op) begin
                    op = cpu_pkg::alu_sub;
                end else begin
                    op = cpu_pkg::alu_add;
                end
            end
            3'b001: op = cpu_pkg::alu_sll;
            3'b010: op = cpu_pkg::alu_slt;
            3'b011: op = cpu_pkg::alu_sltu;
            3'b100: op = cpu_pkg::alu_xor;
            3'b101: begin
                if (alt_op) begin
                    op = cpu_pkg::alu_sra;
                end else begin
                    op = cpu_pkg::alu_srl;
                end
            end
            3'b110: op = cpu_pkg::alu_or;
            default: op = cpu_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign instr    = fetch_out.instr;
    assign opcode   = cpu_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        case (opcode)
            cpu_pkg::op_store: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cpu_pkg::op_branch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            cpu_pkg::op_jal: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            // Upper immediate stays right-justified until execute
            cpu_pkg::op_lui,
            cpu_pkg::op_auipc: imm = {12'b0, instr[31:12]};
            default:           imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            cpu_pkg::op_reg: begin
                ctrl.alu_op    = alu_from_funct(funct3, instr[30]);
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_imm: begin
                ctrl.alu_op    = alu_from_funct(funct3, instr[30] && funct3 == 3'b101);
                ctrl.rd_src2   = cpu_pkg::src2_imm;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_lui: begin
                ctrl.rd_src1   = cpu_pkg::src1_zero;
                ctrl.rd_src2   = cpu_pkg::src2_upper_imm;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_auipc: begin
                ctrl.rd_src1   = cpu_pkg::src1_pc;
                ctrl.rd_src2   = cpu_pkg::src2_upper_imm;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_load: begin
                ctrl.rd_src2   = cpu_pkg::src2_imm;
                ctrl.wb_src    = cpu_pkg::wb_ram;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_store: begin
                ctrl.rd_src2   = cpu_pkg::src2_imm;
                ctrl.ram_write = 1'b1;
            end
            cpu_pkg::op_branch: begin
                // Zero flag decides both branch kinds
                if (funct3[0]) begin
                    ctrl.alu_op  = cpu_pkg::alu_xor;
                    ctrl.next_pc = cpu_pkg::next_if_nonzero;
                end else begin
                    ctrl.alu_op  = cpu_pkg::alu_sub;
                    ctrl.next_pc = cpu_pkg::next_if_zero;
                end
            end
            cpu_pkg::op_jal,
            cpu_pkg::op_jalr: begin
                ctrl.rd_src1   = cpu_pkg::src1_pc;
                ctrl.rd_src2   = cpu_pkg::src2_four;
                ctrl.next_pc   = cpu_pkg::next_always;
                ctrl.reg_write = 1'b1;
                if (opcode == cpu_pkg::op_jalr) begin
                    ctrl.pc_src1 = cpu_pkg::pc_base_rs1;
                end
            end
            cpu_pkg::op_putc: ctrl.putc = 1'b1;
            cpu_pkg::op_halt: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    // x0 ignores writes
    always_ff @(posedge clk) begin
        if (wb_write.en && wb_write.rd != '0) begin
            regs[wb_write.rd] <= wb_write.data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (decode_en) begin
            id_ex.pc   <= fetch_out.pc;
            id_ex.rs1  <= rs1_data;
            id_ex.rs2  <= rs2_data;
            id_ex.imm  <= imm;
            id_ex.rd   <= instr[11:7];
            id_ex.ctrl <= ctrl;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  execute_en,
    input  wire cpu_pkg::id_ex_t id_ex,
    output cpu_pkg::ex_mem_t     ex_mem
);

    cpu_pkg::word_t op1;
    cpu_pkg::word_t op2;
    cpu_pkg::word_t base;
    cpu_pkg::word_t result;
    cpu_pkg::word_t target;

    always_comb begin
        case (id_ex.ctrl.rd_src1)
            cpu_pkg::src1_zero: op1 = '0;
            cpu_pkg::src1_pc:   op1 = id_ex.pc;
            default:            op1 = id_ex.rs1;
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.rd_src2)
            cpu_pkg::src2_imm:       op2 = id_ex.imm;
            cpu_pkg::src2_four:      op2 = cpu_pkg::word_t'(4);
            cpu_pkg::src2_upper_imm: op2 = id_ex.imm << 12;
            default:                 op2 = id_ex.rs2;
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::alu_sub:  result = op1 - op2;
            cpu_pkg::alu_and:  result = op1 & op2;
            cpu_pkg::alu_or:   result = op1 | op2;
            cpu_pkg::alu_xor:  result = op1 ^ op2;
            cpu_pkg::alu_slt:  result = cpu_pkg::word_t'($signed(op1) < $signed(op2));
            cpu_pkg::alu_sltu: result = cpu_pkg::word_t'(op1 < op2);
            cpu_pkg::alu_sll:  result = op1 << op2[4:0];
            cpu_pkg::alu_srl:  result = op1 >> op2[4:0];
            cpu_pkg::alu_sra:  result = cpu_pkg::word_t'($signed(op1) >>> op2[4:0]);
            default:           result = op1 + op2;
        endcase
    end

    assign base = (id_ex.ctrl.pc_src1 == cpu_pkg::pc_base_rs1) ? id_ex.rs1 : id_ex.pc;

    // jalr drops bit 0 of its target
    always_comb begin
        target = base + id_ex.imm;
        if (id_ex.ctrl.pc_src1 == cpu_pkg::pc_base_rs1) begin
            target[0] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (execute_en) begin
            ex_mem.pc         <= id_ex.pc;
            ex_mem.rs1        <= id_ex.rs1;
            ex_mem.rs2        <= id_ex.rs2;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= result;
            ex_mem.zero       <= (result == '0);
            ex_mem.target     <= target;
            ex_mem.ctrl       <= id_ex.ctrl;
        end
    end

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`default_nettype none

module memory_stage (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   memory_en,
    input  wire                   writeback_en,
    input  wire cpu_pkg::ex_mem_t ex_mem,
    input  wire                   out_ready,
    output logic                  out_valid,
    output cpu_pkg::byte_t        out_char,
    output logic                  putc_pending,
    output logic                  halt_seen,
    output cpu_pkg::word_t        next_pc,
    output cpu_pkg::wb_write_t    wb_write
);

    cpu_pkg::word_t     ram [cpu_pkg::ram_depth];
    cpu_pkg::ram_addr_t ram_addr;
    cpu_pkg::word_t     ram_rdata;
    cpu_pkg::word_t     pc_plus4;
    logic               mw_reg_write;
    cpu_pkg::wb_src_e   mw_wb_src;
    cpu_pkg::reg_addr_t mw_rd;
    cpu_pkg::word_t     mw_alu;
    cpu_pkg::word_t     mw_ram;

    // Word addressed by the byte address from the ALU
    assign ram_addr  = cpu_pkg::ram_addr_t'(ex_mem.alu_result >> 2);
    assign ram_rdata = ram[ram_addr];

    always_ff @(posedge clk) begin
        if (memory_en && ex_mem.ctrl.ram_write) begin
            ram[ram_addr] <= ex_mem.rs2;
        end
    end

    assign pc_plus4 = ex_mem.pc + cpu_pkg::word_t'(4);

    always_comb begin
        case (ex_mem.ctrl.next_pc)
            cpu_pkg::next_if_zero:    next_pc = ex_mem.zero ? ex_mem.target : pc_plus4;
            cpu_pkg::next_if_nonzero: next_pc = ex_mem.zero ? pc_plus4 : ex_mem.target;
            cpu_pkg::next_always:     next_pc = ex_mem.target;
            default:                  next_pc = pc_plus4;
        endcase
    end

    assign putc_pending = ex_mem.ctrl.putc;
    assign halt_seen    = ex_mem.ctrl.halt;
    assign out_valid    = memory_en && ex_mem.ctrl.putc;
    assign out_char     = ex_mem.rs1[7:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mw_reg_write <= 1'b0;
            mw_wb_src    <= cpu_pkg::wb_alu;
            mw_rd        <= '0;
            mw_alu       <= '0;
            mw_ram       <= '0;
        end else if (memory_en) begin
            mw_reg_write <= ex_mem.ctrl.reg_write;
            mw_wb_src    <= ex_mem.ctrl.wb_src;
            mw_rd        <= ex_mem.rd;
            mw_alu       <= ex_mem.alu_result;
            mw_ram       <= ram_rdata;
        end
    end

    always_comb begin
        wb_write.en   = writeback_en && mw_reg_write;
        wb_write.rd   = mw_rd;
        wb_write.data = (mw_wb_src == cpu_pkg::wb_ram) ? mw_ram : mw_alu;
    end

    // Byte on offer waits unchanged until the sink takes it
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_char));

endmodule

`default_nettype wire

/* rtl/miyajiro_cpu.sv */
`default_nettype none

module miyajiro_cpu (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 load_valid,
    input  wire cpu_pkg::load_t load,
    input  wire                 out_ready,
    output logic                load_ready,
    output logic                out_valid,
    output cpu_pkg::byte_t      out_char
);

    logic                fetch_en;
    logic                decode_en;
    logic                execute_en;
    logic                memory_en;
    logic                writeback_en;
    logic                putc_pending;
    logic                halt_seen;
    cpu_pkg::word_t      next_pc;
    cpu_pkg::fetch_out_t fetch_out;
    cpu_pkg::id_ex_t     id_ex;
    cpu_pkg::ex_mem_t    ex_mem;
    cpu_pkg::wb_write_t  wb_write;

    stage_sequencer u_stage_sequencer (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_valid   (load_valid),
        .load_last    (load.last),
        .putc_pending (putc_pending),
        .halt_seen    (halt_seen),
        .out_ready    (out_ready),
        .load_ready   (load_ready),
        .fetch_en     (fetch_en),
        .decode_en    (decode_en),
        .execute_en   (execute_en),
        .memory_en    (memory_en),
        .writeback_en (writeback_en)
    );

    fetch_stage u_fetch_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_valid   (load_valid),
        .load_ready   (load_ready),
        .load         (load),
        .fetch_en     (fetch_en),
        .writeback_en (writeback_en),
        .next_pc      (next_pc),
        .fetch_out    (fetch_out)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .decode_en (decode_en),
        .fetch_out (fetch_out),
        .wb_write  (wb_write),
        .id_ex     (id_ex)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .execute_en (execute_en),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem)
    );

    memory_stage u_memory_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .memory_en    (memory_en),
        .writeback_en (writeback_en),
        .ex_mem       (ex_mem),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_char     (out_char),
        .putc_pending (putc_pending),
        .halt_seen    (halt_seen),
        .next_pc      (next_pc),
        .wb_write     (wb_write)
    );

endmodule

`default_nettype wire

/* verification/cpu_tb_model.svh */
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

typedef cpu_pkg::word_t word_q_t [$];
typedef cpu_pkg::byte_t byte_q_t [$];

// Architectural state survives a reload, as in the core
cpu_pkg::word_t model_regs [32] = '{default: '0};
cpu_pkg::word_t model_ram [256] = '{default: '0};

function automatic cpu_pkg::word_t r_type(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic cpu_pkg::word_t i_type(input logic [6:0] op, input int f3, input int rd,
                                          input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic cpu_pkg::word_t s_type(input int rs1, input int rs2, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic cpu_pkg::word_t b_type(input int f3, input int rs1, input int rs2,
                                          input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic cpu_pkg::word_t u_type(input logic [6:0] op, input int rd, input int imm);
    return {imm[19:0], rd[4:0], op};
endfunction

function automatic cpu_pkg::word_t j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic cpu_pkg::word_t addi(input int rd, input int rs1, input int imm);
    return i_type(cpu_pkg::op_imm, 0, rd, rs1, imm);
endfunction

function automatic cpu_pkg::word_t putc(input int rs1);
    return i_type(cpu_pkg::op_putc, 0, 0, rs1, 0);
endfunction

function automatic cpu_pkg::word_t halt();
    return i_type(cpu_pkg::op_halt, 0, 0, 0, 0);
endfunction

function automatic cpu_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
                                             input cpu_pkg::word_t a, input cpu_pkg::word_t b);
    cpu_pkg::word_t r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// Runs a program from pc 0 up to halt and collects the putc bytes
function automatic byte_q_t run_model(input word_q_t p);
    byte_q_t        out;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t ins;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t addr;
    cpu_pkg::word_t res;
    cpu_pkg::word_t npc;
    logic [2:0]     f3;
    logic           wr;
    int             step;
    pc = '0;
    for (step = 0; step < 10000; step++) begin
        if ((pc >> 2) >= p.size()) begin
            return out;
        end
        ins = p[pc >> 2];
        a = model_regs[ins[19:15]];
        b = model_regs[ins[24:20]];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        npc = pc + 4;
        res = '0;
        wr = 1'b1;
        case (ins[6:0])
            cpu_pkg::op_reg:   res = model_alu(f3, ins[30], a, b);
            cpu_pkg::op_imm:   res = model_alu(f3, ins[30] && f3 == 3'd5, a, imm_i);
            cpu_pkg::op_lui:   res = {ins[31:12], 12'b0};
            cpu_pkg::op_auipc: res = pc + {ins[31:12], 12'b0};
            cpu_pkg::op_load: begin
                addr = a + imm_i;
                res = model_ram[addr[9:2]];
            end
            cpu_pkg::op_store: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                model_ram[addr[9:2]] = b;
                wr = 1'b0;
            end
            cpu_pkg::op_branch: begin
                wr = 1'b0;
                // funct3 bit 0 turns beq into bne
                if ((a == b) != f3[0]) begin
                    npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            cpu_pkg::op_jal: begin
                res = pc + 4;
                npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            cpu_pkg::op_jalr: begin
                res = pc + 4;
                npc = (a + imm_i) & ~32'd1;
            end
            cpu_pkg::op_putc: begin
                out.push_back(a[7:0]);
                wr = 1'b0;
            end
            cpu_pkg::op_halt: return out;
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = res;
        end
        pc = npc;
    end
    return out;
endfunction

`endif

/* verification/cpu_tb.sv */
`default_nettype none

module cpu_tb;

    `include "cpu_tb_model.svh"

    logic           clk;
    logic           arst_n;
    logic           load_valid;
    cpu_pkg::load_t load;
    logic           out_ready;
    logic           load_ready;
    logic           out_valid;
    cpu_pkg::byte_t out_char;

    integer         seed = 32'h590;
    int             rnd;
    logic           random_mode;
    int             value_errs;
    int             other_errs;
    cpu_pkg::byte_t expected_q [$];
    cpu_pkg::byte_t exp_char;
    word_q_t        prog;
    word_q_t        countdown;

    miyajiro_cpu u_miyajiro_cpu (
        .clk        (clk),
        .arst_n     (arst_n),
        .load_valid (load_valid),
        .load       (load),
        .out_ready  (out_ready),
        .load_ready (load_ready),
        .out_valid  (out_valid),
        .out_char   (out_char)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Stdout sink, optionally throttled
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            out_ready = rnd[0] || !random_mode;
        end
    end

    // A byte seen here transfers on the next rising edge
    always @(negedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            assert (expected_q.size() != 0) else begin
                other_errs++;
                $display("Unexpected stdout byte %h at %0t", out_char, $time);
            end
            if (expected_q.size() != 0) begin
                exp_char = expected_q.pop_front();
                assert (out_char == exp_char) else begin
                    value_errs++;
                    $display("ERR %0t out_char expected %h actual %h", $time, exp_char, out_char);
                end
            end
        end
    end

    task automatic wait_load_ready(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (load_ready !== level && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        assert (load_ready === level) else begin
            other_errs++;
            $display("Timed out at %0t waiting for load_ready=%0b in %s", $time, level, what);
        end
    endtask

    task automatic load_program(input word_q_t p, input string what);
        int i;
        int tries;
        i = 0;
        tries = 0;
        wait_load_ready(1'b1, what);
        @(posedge clk);
        #1;
        while (i < p.size() && tries < p.size() + 16) begin
            load_valid = 1'b1;
            load.data = p[i];
            load.last = (i == p.size() - 1);
            @(negedge clk);
            if (load_ready) begin
                i++;
            end
            tries++;
            @(posedge clk);
            #1;
        end
        load_valid = 1'b0;
        load.last = 1'b0;
        assert (i == p.size()) else begin
            other_errs++;
            $display("Program load stalled in %s after %0d words", what, i);
        end
    endtask

    task automatic run_program(input word_q_t p, input logic throttle, input string what);
        byte_q_t exp;
        exp = run_model(p);
        foreach (exp[i]) begin
            expected_q.push_back(exp[i]);
        end
        random_mode = throttle;
        load_program(p, what);
        wait_load_ready(1'b0, what);
        wait_load_ready(1'b1, what);
        assert (expected_q.size() == 0) else begin
            other_errs++;
            $display("%s ended with %0d stdout bytes missing", what, expected_q.size());
            expected_q.delete();
        end
    endtask

    initial begin
        arst_n = 1'b0;
        load_valid = 1'b0;
        load = '0;
        random_mode = 1'b0;
        value_errs = 0;
        other_errs = 0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Register and immediate ALU ops, lui, auipc
        prog = '{
            addi(1, 0, 100), addi(2, 0, 7), addi(6, 0, -1), addi(14, 0, 28),
            r_type(0, 0, 3, 1, 2), putc(3), r_type(32, 0, 3, 1, 2), putc(3),
            r_type(0, 7, 3, 1, 2), putc(3), r_type(0, 6, 3, 1, 2), putc(3),
            r_type(0, 4, 3, 1, 2), putc(3), r_type(0, 2, 3, 6, 2), putc(3),
            r_type(0, 3, 3, 6, 2), putc(3), r_type(0, 1, 3, 2, 2), putc(3),
            u_type(cpu_pkg::op_lui, 11, 'h81234),
            r_type(0, 5, 3, 11, 14), putc(3), r_type(32, 5, 3, 11, 14), putc(3),
            i_type(cpu_pkg::op_imm, 4, 3, 1, 15), putc(3),
            i_type(cpu_pkg::op_imm, 6, 3, 1, 3), putc(3),
            i_type(cpu_pkg::op_imm, 7, 3, 6, 'h55), putc(3),
            i_type(cpu_pkg::op_imm, 2, 3, 6, 1), putc(3),
            i_type(cpu_pkg::op_imm, 3, 3, 2, -1), putc(3),
            i_type(cpu_pkg::op_imm, 1, 3, 2, 4), putc(3),
            i_type(cpu_pkg::op_imm, 5, 3, 11, 12), putc(3),
            i_type(cpu_pkg::op_imm, 5, 3, 11, 'h410), putc(3),
            u_type(cpu_pkg::op_auipc, 3, 'h12), putc(3),
            u_type(cpu_pkg::op_lui, 3, 'hABCDE), i_type(cpu_pkg::op_imm, 5, 3, 3, 12), putc(3),
            halt()
        };
        run_program(prog, 1'b0, "alu program");

        prog = '{
            addi(1, 0, 65), addi(2, 0, 'h40), s_type(2, 1, 0),
            addi(1, 1, 1), s_type(2, 1, 8), addi(1, 1, 1), s_type(0, 1, 1020),
            addi(1, 0, 0), i_type(cpu_pkg::op_load, 2, 3, 2, 0), putc(3),
            i_type(cpu_pkg::op_load, 2, 4, 2, 8), putc(4),
            i_type(cpu_pkg::op_load, 2, 5, 0, 1020), putc(5),
            addi(6, 2, 16), i_type(cpu_pkg::op_load, 2, 7, 6, -8), putc(7),
            halt()
        };
        run_program(prog, 1'b0, "ram program");

        // Counts 5 down to 1 and then takes only the second beq
        countdown = '{
            addi(1, 0, 5), addi(2, 0, 'h30),
            r_type(0, 0, 3, 1, 2), putc(3), addi(1, 1, -1), b_type(1, 1, 0, -12),
            b_type(0, 1, 2, 8), b_type(0, 0, 0, 8), putc(2),
            halt()
        };
        run_program(countdown, 1'b0, "branch program");

        prog = '{
            addi(10, 0, 97), j_type(1, 32), addi(5, 1, 48), putc(5),
            addi(6, 0, 37), i_type(cpu_pkg::op_jalr, 0, 1, 6, 0), addi(5, 1, 48), putc(5),
            halt(),
            putc(10), addi(10, 10, 1), i_type(cpu_pkg::op_jalr, 0, 0, 1, 0)
        };
        run_program(prog, 1'b0, "jump program");

        run_program(countdown, 1'b1, "throttled branch program");

        prog = '{
            u_type(cpu_pkg::op_auipc, 1, 0), addi(1, 1, 'h5A), putc(1),
            halt()
        };
        run_program(prog, 1'b0, "reload program");

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verification
rtl/cpu_pkg.sv
rtl/stage_sequencer.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/miyajiro_cpu.sv
verification/cpu_tb.sv

/* Bender.yml */
package:
  name: miyajiro_cpu

sources:
  - rtl/cpu_pkg.sv
  - rtl/stage_sequencer.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/miyajiro_cpu.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cpu_tb.sv
